// ==== hw/isa_pkg.sv ====
// Alpha integer ISA encodings: ALU functions, operand selects, branch conditions
package isa_pkg;

  //////////////////////////////////////////////////
  // ALU function codes
  //////////////////////////////////////////////////
  localparam logic [4:0] alu_addq   = 5'h00;
  localparam logic [4:0] alu_subq   = 5'h01;
  localparam logic [4:0] alu_and    = 5'h02;
  localparam logic [4:0] alu_bic    = 5'h03;
  localparam logic [4:0] alu_bis    = 5'h04;
  localparam logic [4:0] alu_ornot  = 5'h05;
  localparam logic [4:0] alu_xor    = 5'h06;
  localparam logic [4:0] alu_eqv    = 5'h07;
  localparam logic [4:0] alu_srl    = 5'h08;
  localparam logic [4:0] alu_sll    = 5'h09;
  localparam logic [4:0] alu_sra    = 5'h0a;
  localparam logic [4:0] alu_mulq   = 5'h0b;   // Handled by the multiplier
  localparam logic [4:0] alu_cmpeq  = 5'h0c;
  localparam logic [4:0] alu_cmplt  = 5'h0d;
  localparam logic [4:0] alu_cmple  = 5'h0e;
  localparam logic [4:0] alu_cmpult = 5'h0f;
  localparam logic [4:0] alu_cmpule = 5'h10;

  //////////////////////////////////////////////////
  // Operand mux selects
  //////////////////////////////////////////////////
  localparam logic [1:0] opa_is_rega     = 2'h0;
  localparam logic [1:0] opa_is_mem_disp = 2'h1;
  localparam logic [1:0] opa_is_npc      = 2'h2;
  localparam logic [1:0] opa_is_not3     = 2'h3;   // Mask for jump targets

  localparam logic [1:0] opb_is_regb    = 2'h0;
  localparam logic [1:0] opb_is_alu_imm = 2'h1;
  localparam logic [1:0] opb_is_br_disp = 2'h2;

  // Branch conditions, IR bits 28..26
  localparam logic [2:0] br_lbc = 3'h0;
  localparam logic [2:0] br_eq  = 3'h1;
  localparam logic [2:0] br_lt  = 3'h2;
  localparam logic [2:0] br_le  = 3'h3;
  localparam logic [2:0] br_lbs = 3'h4;
  localparam logic [2:0] br_ne  = 3'h5;
  localparam logic [2:0] br_ge  = 3'h6;
  localparam logic [2:0] br_gt  = 3'h7;

endpackage

// ==== hw/ex_pkg.sv ====
// Execute stage datapath widths and result bus encodings
package ex_pkg;

  //////////////////////////////////////////////////
  // Datapath widths
  //////////////////////////////////////////////////
  localparam int xlen         = 64;   // Data and PC
  localparam int inst_bits    = 32;
  localparam int reg_bits     = 5;    // Register tag
  localparam int history_bits = 8;    // PHT index

  // Branch result field on the result buses
  localparam int br_result_bits   = 2;
  localparam int br_res_is_branch = 1;   // Instruction was a branch
  localparam int br_res_taken     = 0;   // Branch was taken

endpackage

// ==== hw/ex_operand_sel.sv ====
// Immediate forms, operand muxes and execution unit decode for one issue bus
`timescale 1ns/1ps

module ex_operand_sel
  import isa_pkg::*, ex_pkg::*;
(
  input  logic [inst_bits-1:0] ir,
  input  logic [xlen-1:0]      npc,
  input  logic [xlen-1:0]      rega,
  input  logic [xlen-1:0]      regb,
  input  logic [1:0]           opa_select,
  input  logic [1:0]           opb_select,
  input  logic [4:0]           alu_func,
  input  logic                 valid,
  input  logic                 cond_branch,
  input  logic                 uncond_branch,
  input  logic                 rd_mem,
  input  logic                 wr_mem,
  output logic [xlen-1:0]      opa,
  output logic [xlen-1:0]      opb,
  output logic                 mult_valid,
  output logic                 alu_valid,
  output logic                 branch_valid,
  output logic                 lsq_valid
);

  logic [xlen-1:0] mem_disp;
  logic [xlen-1:0] br_disp;
  logic [xlen-1:0] alu_imm;
  logic            is_mulq;

  // Immediates pulled from the instruction word
  assign mem_disp = {{(xlen-16){ir[15]}}, ir[15:0]};
  assign br_disp  = {{(xlen-23){ir[20]}}, ir[20:0], 2'b00};   // Word displacement
  assign alu_imm  = {{(xlen-8){1'b0}}, ir[20:13]};

  always_comb
  begin
    opa = rega;
    case (opa_select)
      opa_is_rega:     opa = rega;
      opa_is_mem_disp: opa = mem_disp;
      opa_is_npc:      opa = npc;
      opa_is_not3:     opa = ~xlen'(3);
    endcase
  end

  always_comb
  begin
    opb = '0;   // Only on an illegal select
    case (opb_select)
      opb_is_regb:    opb = regb;
      opb_is_alu_imm: opb = alu_imm;
      opb_is_br_disp: opb = br_disp;
      default:        opb = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // Unit decode
  //////////////////////////////////////////////////
  assign is_mulq      = alu_func == alu_mulq;
  assign mult_valid   = valid && is_mulq;
  assign alu_valid    = valid && !is_mulq && !rd_mem;   // Loads complete via memory
  assign branch_valid = valid && (cond_branch || uncond_branch);
  assign lsq_valid    = valid && (rd_mem || wr_mem);

  always_comb
  begin
    if (valid)
      assert (opb_select != 2'h3) else $error("opb_select has the illegal value");
  end

endmodule

// ==== hw/ex_alu.sv ====
// Integer ALU with branch condition test, taken and mispredict logic
`timescale 1ns/1ps

module ex_alu
  import isa_pkg::*, ex_pkg::*;
(
  input  logic [xlen-1:0]      opa,
  input  logic [xlen-1:0]      opb,
  input  logic [4:0]           func,
  input  logic [xlen-1:0]      rega,
  input  logic [inst_bits-1:0] ir,
  input  logic                 cond_branch,
  input  logic                 uncond_branch,
  input  logic                 branch_valid,
  input  logic [xlen-1:0]      npc,
  input  logic [xlen-1:0]      ppc,
  output logic [xlen-1:0]      result,
  output logic                 branch_taken,
  output logic                 mispredict
);

  localparam int shamt_bits = $clog2(xlen);

  logic signed [xlen-1:0] sa;
  logic signed [xlen-1:0] sb;
  logic [shamt_bits-1:0]  shamt;
  logic                   cond_true;
  logic [xlen-1:0]        next_pc;

  assign sa    = opa;
  assign sb    = opb;
  assign shamt = opb[shamt_bits-1:0];

  always_comb
  begin
    case (func)
      alu_addq:   result = opa + opb;
      alu_subq:   result = opa - opb;
      alu_and:    result = opa & opb;
      alu_bic:    result = opa & ~opb;
      alu_bis:    result = opa | opb;
      alu_ornot:  result = opa | ~opb;
      alu_xor:    result = opa ^ opb;
      alu_eqv:    result = opa ^ ~opb;
      alu_srl:    result = opa >> shamt;
      alu_sll:    result = opa << shamt;
      alu_sra:    result = sa >>> shamt;
      alu_cmpeq:  result = xlen'(opa == opb);
      alu_cmplt:  result = xlen'(sa < sb);
      alu_cmple:  result = xlen'(sa <= sb);
      alu_cmpult: result = xlen'(opa < opb);
      alu_cmpule: result = xlen'(opa <= opb);
      default:    result = '0;   // MULQ and unused codes
    endcase
  end

  //////////////////////////////////////////////////
  // Branch resolution
  //////////////////////////////////////////////////
  always_comb
  begin
    cond_true = 1'b0;
    case (ir[28:26])   // Condition is always tested on rega
      br_lbc: cond_true = !rega[0];
      br_eq:  cond_true = rega == '0;
      br_lt:  cond_true = rega[xlen-1];
      br_le:  cond_true = rega[xlen-1] || rega == '0;
      br_lbs: cond_true = rega[0];
      br_ne:  cond_true = rega != '0;
      br_ge:  cond_true = !rega[xlen-1];
      br_gt:  cond_true = !rega[xlen-1] && rega != '0;
    endcase
  end

  assign branch_taken = uncond_branch || (cond_branch && cond_true);

  // Target comes from the ALU, fall-through is NPC
  assign next_pc    = branch_taken ? result : npc;
  assign mispredict = branch_valid && (next_pc != ppc);

endmodule

// ==== hw/mult.sv ====
// Stallable pipelined multiplier, low 64 bits of the product, carrying NPC and tag
`timescale 1ns/1ps

module mult
  import ex_pkg::*;
#(
  parameter int mult_stages = 4
)
(
  input  logic                clock,
  input  logic                reset,
  input  logic                valid_in,
  input  logic                stall,
  input  logic [xlen-1:0]     mplier,
  input  logic [xlen-1:0]     mcand,
  input  logic [xlen-1:0]     npc_in,
  input  logic [reg_bits-1:0] dest_reg_in,
  output logic                valid_out,
  output logic [xlen-1:0]     product,
  output logic [xlen-1:0]     npc_out,
  output logic [reg_bits-1:0] dest_reg_out
);

  localparam int chunk = xlen / mult_stages;   // Multiplier bits per stage

  // Index 0 is the issue side, index s+1 the register of stage s
  logic                valid_r    [mult_stages+1];
  logic [xlen-1:0]     prod_r     [mult_stages+1];
  logic [xlen-1:0]     mplier_r   [mult_stages+1];
  logic [xlen-1:0]     mcand_r    [mult_stages+1];
  logic [xlen-1:0]     npc_r      [mult_stages+1];
  logic [reg_bits-1:0] dest_reg_r [mult_stages+1];

  assign valid_r[0]    = valid_in;
  assign prod_r[0]     = '0;
  assign mplier_r[0]   = mplier;
  assign mcand_r[0]    = mcand;
  assign npc_r[0]      = npc_in;
  assign dest_reg_r[0] = dest_reg_in;

  for (genvar s = 0; s < mult_stages; s++)
  begin : g_stage
    always_ff @(posedge clock)
    begin
      if (reset)
        valid_r[s+1] <= 1'b0;
      else if (!stall)
        valid_r[s+1] <= valid_r[s];
    end

    // Partial product of the low chunk, then slide both operands along
    always_ff @(posedge clock)
    begin
      if (!stall)
      begin
        prod_r[s+1]     <= prod_r[s] + mplier_r[s][chunk-1:0] * mcand_r[s];
        mplier_r[s+1]   <= mplier_r[s] >> chunk;
        mcand_r[s+1]    <= mcand_r[s] << chunk;
        npc_r[s+1]      <= npc_r[s];
        dest_reg_r[s+1] <= dest_reg_r[s];
      end
    end
  end

  assign valid_out    = valid_r[mult_stages];
  assign product      = prod_r[mult_stages];
  assign npc_out      = npc_r[mult_stages];
  assign dest_reg_out = dest_reg_r[mult_stages];

  a_valid_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(valid_out));

endmodule

// ==== hw/ex_arbiter.sv ====
// Result bus arbitration among ALU, multiplier and memory return, with stall generation
`timescale 1ns/1ps

module ex_arbiter
  import ex_pkg::*;
(
  input  logic                      alu_valid_1, alu_valid_2,
  input  logic                      branch_valid_1, branch_valid_2,
  input  logic                      branch_taken_1, branch_taken_2,
  input  logic                      mispredict_1, mispredict_2,
  input  logic [history_bits-1:0]   pht_idx_1, pht_idx_2,
  input  logic [xlen-1:0]           npc_1, npc_2,
  input  logic [reg_bits-1:0]       dest_reg_1, dest_reg_2,
  input  logic [xlen-1:0]           alu_result_1, alu_result_2,
  input  logic                      mult_valid_1, mult_valid_2,
  input  logic [xlen-1:0]           mult_npc_1, mult_npc_2,
  input  logic [reg_bits-1:0]       mult_dest_reg_1, mult_dest_reg_2,
  input  logic [xlen-1:0]           mult_result_1, mult_result_2,
  input  logic                      mult_valid_in_2,   // MULQ offered on bus 2
  input  logic [reg_bits-1:0]       mem_tag,
  input  logic [xlen-1:0]           mem_value,
  input  logic                      mem_valid,
  output logic                      stall_bus_1, stall_bus_2, stall_mult_2,
  output logic [xlen-1:0]           ex_npc_1, ex_npc_2,
  output logic [reg_bits-1:0]       ex_dest_reg_1, ex_dest_reg_2,
  output logic [xlen-1:0]           ex_result_1, ex_result_2,
  output logic                      ex_mispredict_1, ex_mispredict_2,
  output logic [br_result_bits-1:0] ex_branch_result_1, ex_branch_result_2,
  output logic [history_bits-1:0]   ex_pht_idx_1, ex_pht_idx_2,
  output logic                      ex_valid_1, ex_valid_2
);

  logic want_1;
  logic want_2;
  logic grant_mult_1;
  logic grant_alu_1;
  logic grant_mem;
  logic grant_mult_2;
  logic grant_alu_2;

  //////////////////////////////////////////////////
  // Fixed priority grants
  //////////////////////////////////////////////////
  assign want_1       = alu_valid_1 || branch_valid_1;
  assign want_2       = alu_valid_2 || branch_valid_2;
  assign grant_mult_1 = mult_valid_1;
  assign grant_alu_1  = want_1 && !grant_mult_1;
  assign grant_mem    = mem_valid;
  assign grant_mult_2 = mult_valid_2 && !mem_valid;   // Memory return goes first
  assign grant_alu_2  = want_2 && !mem_valid && !mult_valid_2;

  assign stall_mult_2 = mem_valid;   // Freeze bus 2 multiplier behind a memory return
  assign stall_bus_1  = want_1 && grant_mult_1;
  assign stall_bus_2  = (want_2 && !grant_alu_2) || (mult_valid_in_2 && stall_mult_2);

  // Bus 1 result
  always_comb
  begin
    ex_valid_1         = grant_mult_1 || grant_alu_1;
    ex_npc_1           = grant_mult_1 ? mult_npc_1 : npc_1;
    ex_dest_reg_1      = grant_mult_1 ? mult_dest_reg_1 : dest_reg_1;
    ex_result_1        = grant_mult_1 ? mult_result_1 : alu_result_1;
    ex_branch_result_1 = '0;
    ex_mispredict_1    = 1'b0;
    ex_pht_idx_1       = '0;
    if (grant_alu_1 && branch_valid_1)
    begin
      ex_branch_result_1[br_res_is_branch] = 1'b1;
      ex_branch_result_1[br_res_taken]     = branch_taken_1;
      ex_mispredict_1                      = mispredict_1;
      ex_pht_idx_1                         = pht_idx_1;
    end
  end

  // Bus 2 result
  always_comb
  begin
    ex_valid_2         = grant_mem || grant_mult_2 || grant_alu_2;
    ex_npc_2           = npc_2;
    ex_dest_reg_2      = dest_reg_2;
    ex_result_2        = alu_result_2;
    ex_branch_result_2 = '0;
    ex_mispredict_2    = 1'b0;
    ex_pht_idx_2       = '0;
    if (grant_mem)
    begin
      ex_npc_2      = '0;   // No PC comes back with a load
      ex_dest_reg_2 = mem_tag;
      ex_result_2   = mem_value;
    end
    else if (grant_mult_2)
    begin
      ex_npc_2      = mult_npc_2;
      ex_dest_reg_2 = mult_dest_reg_2;
      ex_result_2   = mult_result_2;
    end
    else if (grant_alu_2 && branch_valid_2)
    begin
      ex_branch_result_2[br_res_is_branch] = 1'b1;
      ex_branch_result_2[br_res_taken]     = branch_taken_2;
      ex_mispredict_2                      = mispredict_2;
      ex_pht_idx_2                         = pht_idx_2;
    end
  end

endmodule

// ==== hw/ex_stage.sv ====
// Two-way execute stage: operand lanes, ALUs, multipliers, result arbiter, LSQ outputs
`timescale 1ns/1ps

module ex_stage
  import ex_pkg::*;
#(
  parameter int mult_stages = 4
)
(
  input  logic                      clock,
  input  logic                      reset,
  // Issue buses
  input  logic                      valid_in_1, valid_in_2,
  input  logic [xlen-1:0]           npc_1, npc_2,
  input  logic [xlen-1:0]           ppc_1, ppc_2,   // Predicted next PC
  input  logic [history_bits-1:0]   pht_idx_1, pht_idx_2,
  input  logic [inst_bits-1:0]      ir_1, ir_2,
  input  logic [reg_bits-1:0]       dest_reg_1, dest_reg_2,
  input  logic [xlen-1:0]           rega_1, rega_2,
  input  logic [xlen-1:0]           regb_1, regb_2,
  input  logic [1:0]                opa_select_1, opa_select_2,
  input  logic [1:0]                opb_select_1, opb_select_2,
  input  logic [4:0]                alu_func_1, alu_func_2,
  input  logic                      cond_branch_1, cond_branch_2,
  input  logic                      uncond_branch_1, uncond_branch_2,
  input  logic                      rd_mem_1, rd_mem_2,
  input  logic                      wr_mem_1, wr_mem_2,
  // Memory return
  input  logic [reg_bits-1:0]       mem_tag,
  input  logic [xlen-1:0]           mem_value,
  input  logic                      mem_valid,
  // Back to issue
  output logic                      stall_bus_1, stall_bus_2,
  // Result buses
  output logic [xlen-1:0]           ex_npc_1, ex_npc_2,
  output logic [reg_bits-1:0]       ex_dest_reg_1, ex_dest_reg_2,
  output logic [xlen-1:0]           ex_result_1, ex_result_2,
  output logic                      ex_mispredict_1, ex_mispredict_2,
  output logic [br_result_bits-1:0] ex_branch_result_1, ex_branch_result_2,
  output logic [history_bits-1:0]   ex_pht_idx_1, ex_pht_idx_2,
  output logic                      ex_valid_1, ex_valid_2,
  // Load/store queue
  output logic [reg_bits-1:0]       lsq_tag_1, lsq_tag_2,
  output logic [xlen-1:0]           lsq_address_1, lsq_address_2,
  output logic [xlen-1:0]           lsq_value_1, lsq_value_2,
  output logic                      lsq_valid_1, lsq_valid_2
);

  logic [xlen-1:0]     opa_1, opa_2, opb_1, opb_2;
  logic                mult_valid_in_1, mult_valid_in_2;
  logic                alu_valid_1, alu_valid_2, branch_valid_1, branch_valid_2;
  logic [xlen-1:0]     alu_result_1, alu_result_2;
  logic                branch_taken_1, branch_taken_2, mispredict_1, mispredict_2;
  logic                mult_valid_1, mult_valid_2;
  logic [xlen-1:0]     mult_npc_1, mult_npc_2, mult_result_1, mult_result_2;
  logic [reg_bits-1:0] mult_dest_reg_1, mult_dest_reg_2;
  logic                stall_mult_2;

  //////////////////////////////////////////////////
  // Lane 1
  //////////////////////////////////////////////////
  ex_operand_sel sel_1 (
    .ir(ir_1), .npc(npc_1), .rega(rega_1), .regb(regb_1),
    .opa_select(opa_select_1), .opb_select(opb_select_1), .alu_func(alu_func_1),
    .valid(valid_in_1), .cond_branch(cond_branch_1), .uncond_branch(uncond_branch_1),
    .rd_mem(rd_mem_1), .wr_mem(wr_mem_1), .opa(opa_1), .opb(opb_1),
    .mult_valid(mult_valid_in_1), .alu_valid(alu_valid_1),
    .branch_valid(branch_valid_1), .lsq_valid(lsq_valid_1)
  );

  ex_alu alu_1 (
    .opa(opa_1), .opb(opb_1), .func(alu_func_1), .rega(rega_1), .ir(ir_1),
    .cond_branch(cond_branch_1), .uncond_branch(uncond_branch_1),
    .branch_valid(branch_valid_1), .npc(npc_1), .ppc(ppc_1),
    .result(alu_result_1), .branch_taken(branch_taken_1), .mispredict(mispredict_1)
  );

  mult #(.mult_stages(mult_stages)) mult_1 (
    .clock(clock), .reset(reset), .valid_in(mult_valid_in_1), .stall(1'b0),
    .mplier(opa_1), .mcand(opb_1), .npc_in(npc_1), .dest_reg_in(dest_reg_1),
    .valid_out(mult_valid_1), .product(mult_result_1), .npc_out(mult_npc_1),
    .dest_reg_out(mult_dest_reg_1)
  );

  //////////////////////////////////////////////////
  // Lane 2
  //////////////////////////////////////////////////
  ex_operand_sel sel_2 (
    .ir(ir_2), .npc(npc_2), .rega(rega_2), .regb(regb_2),
    .opa_select(opa_select_2), .opb_select(opb_select_2), .alu_func(alu_func_2),
    .valid(valid_in_2), .cond_branch(cond_branch_2), .uncond_branch(uncond_branch_2),
    .rd_mem(rd_mem_2), .wr_mem(wr_mem_2), .opa(opa_2), .opb(opb_2),
    .mult_valid(mult_valid_in_2), .alu_valid(alu_valid_2),
    .branch_valid(branch_valid_2), .lsq_valid(lsq_valid_2)
  );

  ex_alu alu_2 (
    .opa(opa_2), .opb(opb_2), .func(alu_func_2), .rega(rega_2), .ir(ir_2),
    .cond_branch(cond_branch_2), .uncond_branch(uncond_branch_2),
    .branch_valid(branch_valid_2), .npc(npc_2), .ppc(ppc_2),
    .result(alu_result_2), .branch_taken(branch_taken_2), .mispredict(mispredict_2)
  );

  mult #(.mult_stages(mult_stages)) mult_2 (
    .clock(clock), .reset(reset), .valid_in(mult_valid_in_2), .stall(stall_mult_2),
    .mplier(opa_2), .mcand(opb_2), .npc_in(npc_2), .dest_reg_in(dest_reg_2),
    .valid_out(mult_valid_2), .product(mult_result_2), .npc_out(mult_npc_2),
    .dest_reg_out(mult_dest_reg_2)
  );

  ex_arbiter arb (
    .alu_valid_1(alu_valid_1), .alu_valid_2(alu_valid_2),
    .branch_valid_1(branch_valid_1), .branch_valid_2(branch_valid_2),
    .branch_taken_1(branch_taken_1), .branch_taken_2(branch_taken_2),
    .mispredict_1(mispredict_1), .mispredict_2(mispredict_2),
    .pht_idx_1(pht_idx_1), .pht_idx_2(pht_idx_2), .npc_1(npc_1), .npc_2(npc_2),
    .dest_reg_1(dest_reg_1), .dest_reg_2(dest_reg_2),
    .alu_result_1(alu_result_1), .alu_result_2(alu_result_2),
    .mult_valid_1(mult_valid_1), .mult_valid_2(mult_valid_2),
    .mult_npc_1(mult_npc_1), .mult_npc_2(mult_npc_2),
    .mult_dest_reg_1(mult_dest_reg_1), .mult_dest_reg_2(mult_dest_reg_2),
    .mult_result_1(mult_result_1), .mult_result_2(mult_result_2),
    .mult_valid_in_2(mult_valid_in_2),
    .mem_tag(mem_tag), .mem_value(mem_value), .mem_valid(mem_valid),
    .stall_bus_1(stall_bus_1), .stall_bus_2(stall_bus_2), .stall_mult_2(stall_mult_2),
    .ex_npc_1(ex_npc_1), .ex_npc_2(ex_npc_2),
    .ex_dest_reg_1(ex_dest_reg_1), .ex_dest_reg_2(ex_dest_reg_2),
    .ex_result_1(ex_result_1), .ex_result_2(ex_result_2),
    .ex_mispredict_1(ex_mispredict_1), .ex_mispredict_2(ex_mispredict_2),
    .ex_branch_result_1(ex_branch_result_1), .ex_branch_result_2(ex_branch_result_2),
    .ex_pht_idx_1(ex_pht_idx_1), .ex_pht_idx_2(ex_pht_idx_2),
    .ex_valid_1(ex_valid_1), .ex_valid_2(ex_valid_2)
  );

  // LSQ gets the effective address from the ALU, store data from rega
  assign lsq_tag_1     = dest_reg_1;
  assign lsq_address_1 = alu_result_1;
  assign lsq_value_1   = rega_1;
  assign lsq_tag_2     = dest_reg_2;
  assign lsq_address_2 = alu_result_2;
  assign lsq_value_2   = rega_2;

endmodule

// ==== verif/tb_clock.sv ====
// Testbench clock and synchronous reset generator
`timescale 1ns/1ps

module tb_clock #(
  parameter int period       = 100,
  parameter int reset_cycles = 16
)
(
  output logic clock,
  output logic reset
);

  initial
  begin
    clock = 1'b0;
    forever #(period/2) clock = ~clock;
  end

  initial
  begin
    reset = 1'b1;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;   // Released away from the active edge
  end

endmodule

// ==== verif/ex_stage_tb.sv ====
// Execute stage testbench: random stimulus, reference model, comparison process, report
`timescale 1ns/1ps

module ex_stage_tb
  import isa_pkg::*, ex_pkg::*;
;

  localparam int stages = 4;
  localparam int cycle_limit = 16 + 600 + 40;

  logic clock, reset;
  logic valid_in [1:2], cond_br [1:2], uncond_br [1:2], rd_mem [1:2], wr_mem [1:2];
  logic [63:0] npc [1:2], ppc [1:2], rega [1:2], regb [1:2];
  logic [7:0] pht_idx [1:2];
  logic [31:0] ir [1:2];
  logic [4:0] dest_reg [1:2], alu_func [1:2];
  logic [1:0] opa_sel [1:2], opb_sel [1:2];
  logic [4:0] mem_tag;
  logic [63:0] mem_value;
  logic mem_valid;
  logic stall [1:2], ex_mispredict [1:2], ex_valid [1:2], lsq_valid [1:2];
  logic [63:0] ex_npc [1:2], ex_result [1:2], lsq_address [1:2], lsq_value [1:2];
  logic [4:0] ex_dest_reg [1:2], lsq_tag [1:2];
  logic [1:0] ex_branch_result [1:2];
  logic [7:0] ex_pht_idx [1:2];
  logic held [1:2];   // Stall seen at the last rising edge

  logic [31:0] lcg_state = 32'hfbd7;
  string test_name = "reset";
  int errors = 0;
  int checks = 0;
  int cyc = 0;
  int tick = 0;
  int q_due [1:2][$];
  logic [63:0] q_prod [1:2][$];
  logic [63:0] q_npc [1:2][$];
  logic [4:0] q_dest [1:2][$];

  tb_clock #(.period(100), .reset_cycles(16)) clk_gen (.clock(clock), .reset(reset));

  ex_stage #(.mult_stages(stages)) ex_stage_i (
    .clock(clock), .reset(reset),
    .valid_in_1(valid_in[1]), .valid_in_2(valid_in[2]), .npc_1(npc[1]), .npc_2(npc[2]),
    .ppc_1(ppc[1]), .ppc_2(ppc[2]), .pht_idx_1(pht_idx[1]), .pht_idx_2(pht_idx[2]),
    .ir_1(ir[1]), .ir_2(ir[2]), .dest_reg_1(dest_reg[1]), .dest_reg_2(dest_reg[2]),
    .rega_1(rega[1]), .rega_2(rega[2]), .regb_1(regb[1]), .regb_2(regb[2]),
    .opa_select_1(opa_sel[1]), .opa_select_2(opa_sel[2]),
    .opb_select_1(opb_sel[1]), .opb_select_2(opb_sel[2]),
    .alu_func_1(alu_func[1]), .alu_func_2(alu_func[2]),
    .cond_branch_1(cond_br[1]), .cond_branch_2(cond_br[2]),
    .uncond_branch_1(uncond_br[1]), .uncond_branch_2(uncond_br[2]),
    .rd_mem_1(rd_mem[1]), .rd_mem_2(rd_mem[2]), .wr_mem_1(wr_mem[1]), .wr_mem_2(wr_mem[2]),
    .mem_tag(mem_tag), .mem_value(mem_value), .mem_valid(mem_valid),
    .stall_bus_1(stall[1]), .stall_bus_2(stall[2]),
    .ex_npc_1(ex_npc[1]), .ex_npc_2(ex_npc[2]),
    .ex_dest_reg_1(ex_dest_reg[1]), .ex_dest_reg_2(ex_dest_reg[2]),
    .ex_result_1(ex_result[1]), .ex_result_2(ex_result[2]),
    .ex_mispredict_1(ex_mispredict[1]), .ex_mispredict_2(ex_mispredict[2]),
    .ex_branch_result_1(ex_branch_result[1]), .ex_branch_result_2(ex_branch_result[2]),
    .ex_pht_idx_1(ex_pht_idx[1]), .ex_pht_idx_2(ex_pht_idx[2]),
    .ex_valid_1(ex_valid[1]), .ex_valid_2(ex_valid[2]),
    .lsq_tag_1(lsq_tag[1]), .lsq_tag_2(lsq_tag[2]),
    .lsq_address_1(lsq_address[1]), .lsq_address_2(lsq_address[2]),
    .lsq_value_1(lsq_value[1]), .lsq_value_2(lsq_value[2]),
    .lsq_valid_1(lsq_valid[1]), .lsq_valid_2(lsq_valid[2])
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  //////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////
  function automatic logic [63:0] pick_opa(int k);
    case (opa_sel[k])
      2'd0:    return rega[k];
      2'd1:    return {{48{ir[k][15]}}, ir[k][15:0]};
      2'd2:    return npc[k];
      default: return ~64'd3;
    endcase
  endfunction

  function automatic logic [63:0] pick_opb(int k);
    case (opb_sel[k])
      2'd0:    return regb[k];
      2'd1:    return {56'd0, ir[k][20:13]};
      default: return {{41{ir[k][20]}}, ir[k][20:0], 2'b00};
    endcase
  endfunction

  // Returns {result, taken, mispredict}
  function automatic logic [65:0] ref_exec(int k);
    logic [63:0] a, b, res, next;
    logic holds, taken, mis;
    a = pick_opa(k);
    b = pick_opb(k);
    case (alu_func[k])
      alu_addq:   res = a + b;
      alu_subq:   res = a - b;
      alu_and:    res = a & b;
      alu_bic:    res = a & ~b;
      alu_bis:    res = a | b;
      alu_ornot:  res = a | ~b;
      alu_xor:    res = a ^ b;
      alu_eqv:    res = ~(a ^ b);
      alu_srl:    res = a >> b[5:0];
      alu_sll:    res = a << b[5:0];
      alu_sra:    res = $signed(a) >>> b[5:0];
      alu_cmpeq:  res = {63'd0, a == b};
      alu_cmplt:  res = {63'd0, $signed(a) < $signed(b)};
      alu_cmple:  res = {63'd0, $signed(a) <= $signed(b)};
      alu_cmpult: res = {63'd0, a < b};
      alu_cmpule: res = {63'd0, a <= b};
      default:    res = 64'd0;
    endcase
    case (ir[k][28:26])
      br_lbc:  holds = !rega[k][0];
      br_eq:   holds = rega[k] == 64'd0;
      br_lt:   holds = $signed(rega[k]) < 0;
      br_le:   holds = $signed(rega[k]) <= 0;
      br_lbs:  holds = rega[k][0];
      br_ne:   holds = rega[k] != 64'd0;
      br_ge:   holds = $signed(rega[k]) >= 0;
      default: holds = $signed(rega[k]) > 0;
    endcase
    taken = uncond_br[k] || (cond_br[k] && holds);
    next = taken ? res : npc[k];
    mis = valid_in[k] && (cond_br[k] || uncond_br[k]) && next != ppc[k];
    return {res, taken, mis};
  endfunction

  task automatic expect_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
    checks++;
    if (act !== exp)
    begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  //////////////////////////////////////////////////
  // Comparison at the rising edge
  //////////////////////////////////////////////////
  task automatic check_bus(int k, logic mem);
    logic [65:0] r;
    logic want, mdue, is_br;
    r = ref_exec(k);
    is_br = valid_in[k] && (cond_br[k] || uncond_br[k]);
    want = is_br || (valid_in[k] && alu_func[k] != alu_mulq && !rd_mem[k]);
    mdue = q_due[k].size() > 0 && q_due[k][0] == cyc;
    expect_eq($sformatf("stall_bus_%0d", k), {63'd0, (want && (mem || mdue))
      || (k == 2 && mem && valid_in[2] && alu_func[2] == alu_mulq)}, {63'd0, stall[k]});
    expect_eq($sformatf("ex_valid_%0d", k), {63'd0, mem || mdue || want}, {63'd0, ex_valid[k]});
    if (mem)
    begin
      expect_eq("mem result", mem_value, ex_result[k]);
      expect_eq("mem tag", {59'd0, mem_tag}, {59'd0, ex_dest_reg[k]});
    end
    else if (mdue)
    begin
      expect_eq("product", q_prod[k][0], ex_result[k]);
      expect_eq("mult npc", q_npc[k][0], ex_npc[k]);
      expect_eq("mult dest", {59'd0, q_dest[k][0]}, {59'd0, ex_dest_reg[k]});
      expect_eq("mult branch", 64'd0, {62'd0, ex_branch_result[k]});
    end
    else if (want)
    begin
      expect_eq("alu result", r[65:2], ex_result[k]);
      expect_eq("npc", npc[k], ex_npc[k]);
      expect_eq("dest", {59'd0, dest_reg[k]}, {59'd0, ex_dest_reg[k]});
      expect_eq("branch_result", {62'd0, is_br, is_br && r[1]}, {62'd0, ex_branch_result[k]});
      expect_eq("mispredict", {63'd0, is_br && r[0]}, {63'd0, ex_mispredict[k]});
      expect_eq("pht_idx", is_br ? {56'd0, pht_idx[k]} : 64'd0, {56'd0, ex_pht_idx[k]});
    end
    expect_eq("lsq_valid", {63'd0, valid_in[k] && (rd_mem[k] || wr_mem[k])},
      {63'd0, lsq_valid[k]});
    if (valid_in[k] && (rd_mem[k] || wr_mem[k]))
    begin
      expect_eq("lsq_address", r[65:2], lsq_address[k]);
      expect_eq("lsq_value", rega[k], lsq_value[k]);
      expect_eq("lsq_tag", {59'd0, dest_reg[k]}, {59'd0, lsq_tag[k]});
    end
  endtask

  task automatic track_mult(int k, logic hold);
    if (q_due[k].size() > 0 && q_due[k][0] == cyc && !hold)
    begin
      void'(q_due[k].pop_front());
      void'(q_prod[k].pop_front());
      void'(q_npc[k].pop_front());
      void'(q_dest[k].pop_front());
    end
    if (hold)
      for (int i = 0; i < q_due[k].size(); i++)
        q_due[k][i]++;   // Whole pipe frozen one cycle
    if (valid_in[k] && alu_func[k] == alu_mulq && !hold)
    begin
      q_due[k].push_back(cyc + stages);
      q_prod[k].push_back(pick_opa(k) * pick_opb(k));
      q_npc[k].push_back(npc[k]);
      q_dest[k].push_back(dest_reg[k]);
    end
  endtask

  always @(posedge clock)
  begin
    if (!reset)
    begin
      held[1] = stall[1];
      held[2] = stall[2];
      check_bus(1, 1'b0);
      check_bus(2, mem_valid);
      track_mult(1, 1'b0);
      track_mult(2, mem_valid);
      cyc++;
    end
  end

  always @(posedge clock)
  begin
    tick++;
    if (tick >= cycle_limit)
    begin
      $display("Timeout: run did not finish within %0d cycles", cycle_limit);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Stimulus driven on the falling edge
  //////////////////////////////////////////////////
  task automatic idle_bus(int k);
    valid_in[k] = 0;
    cond_br[k] = 0;
    uncond_br[k] = 0;
    rd_mem[k] = 0;
    wr_mem[k] = 0;
    opa_sel[k] = 0;
    opb_sel[k] = 0;
    alu_func[k] = 0;
  endtask

  task automatic random_alu(int k);
    logic [4:0] f;
    idle_bus(k);
    f = 5'(lcg_next() % 17);
    valid_in[k] = 1;
    alu_func[k] = (f == alu_mulq) ? alu_addq : f;
    opa_sel[k] = 2'(lcg_next() % 4);
    opb_sel[k] = 2'(lcg_next() % 3);
    ir[k] = lcg_next();
    rega[k] = {lcg_next(), lcg_next()};
    regb[k] = {lcg_next(), lcg_next()};
    npc[k] = {lcg_next(), lcg_next() & 32'hffff_fffc};
    ppc[k] = npc[k];
    dest_reg[k] = 5'(lcg_next());
    pht_idx[k] = 8'(lcg_next());
  endtask

  task automatic random_branch(int k);
    logic [65:0] r;
    logic [63:0] next;
    random_alu(k);
    alu_func[k] = alu_addq;
    opa_sel[k] = (lcg_next() % 4 == 0) ? opa_is_rega : opa_is_npc;
    opb_sel[k] = opb_is_br_disp;
    cond_br[k] = lcg_next() % 4 != 0;
    uncond_br[k] = !cond_br[k];
    case (lcg_next() % 4)   // Edge values for the condition
      0: rega[k] = 64'd0;
      1: rega[k] = 64'd1;
      2: rega[k] = '1;
      default: ;
    endcase
    r = ref_exec(k);
    next = r[1] ? r[65:2] : npc[k];
    ppc[k] = (lcg_next() % 2 == 0) ? next : next + 64'd4;
  endtask

  task automatic random_mul(int k);
    random_alu(k);
    if (lcg_next() % 2 == 0)
      alu_func[k] = alu_mulq;
  endtask

  task automatic random_mem_op(int k);
    random_alu(k);
    alu_func[k] = alu_addq;
    opa_sel[k] = opa_is_mem_disp;
    opb_sel[k] = opb_is_regb;
    rd_mem[k] = lcg_next() % 2 == 0;
    wr_mem[k] = !rd_mem[k];
  endtask

  task automatic run_phase(string name, int n, int kind);
    test_name = name;
    repeat (n)
    begin
      @(negedge clock);
      for (int k = 1; k <= 2; k++)
      begin
        if (held[k])
          continue;   // Issue holds a stalled instruction
        case (kind)
          0: random_alu(k);
          1: random_branch(k);
          2: random_mul(k);
          3: random_mem_op(k);
          default: idle_bus(k);
        endcase
      end
      mem_valid = (kind == 2 && name == "memory") ? (lcg_next() % 3 == 0) : 1'b0;
      mem_tag = 5'(lcg_next());
      mem_value = {lcg_next(), lcg_next()};
    end
  endtask

  initial
  begin
    for (int k = 1; k <= 2; k++)
    begin
      idle_bus(k);
      npc[k] = 0;
      ppc[k] = 0;
      rega[k] = 0;
      regb[k] = 0;
      ir[k] = 0;
      dest_reg[k] = 0;
      pht_idx[k] = 0;
      held[k] = 0;
    end
    mem_valid = 0;
    mem_tag = 0;
    mem_value = 0;
    @(negedge reset);
    run_phase("alu", 150, 0);
    run_phase("branch", 120, 1);
    run_phase("mulq", 100, 2);
    run_phase("memory", 120, 2);
    run_phase("load_store", 80, 3);
    run_phase("drain", 10, 4);
    if (q_due[1].size() != 0 || q_due[2].size() != 0)
    begin
      errors++;
      $display("Multiply results still pending after the drain cycles");
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation finished: PASS");
    else
      $display("Simulation finished: FAIL");
    $finish;
  end

endmodule

// ==== all.f ====
hw/isa_pkg.sv
hw/ex_pkg.sv
hw/ex_operand_sel.sv
hw/ex_alu.sv
hw/mult.sv
hw/ex_arbiter.sv
hw/ex_stage.sv
verif/tb_clock.sv
verif/ex_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing -Wno-fatal -f all.f --top-module ex_stage_tb \
    -o ex_stage_sim; then
  echo "Verilator build failed"
  exit 1
fi

if ! ./obj_dir/ex_stage_sim > sim.log 2>&1; then
  cat sim.log
  echo "Simulation run returned an error status"
  exit 1
fi

cat sim.log

if grep -q "Simulation finished: FAIL" sim.log; then
  exit 1
fi
if ! grep -q "Simulation finished: PASS" sim.log; then
  echo "No result line found in sim.log"
  exit 1
fi
exit 0
